// File: bp_pkg.sv
package bp_pkg;

    localparam int XLEN   = 32;
    localparam int HIST_W = 10;

    typedef logic [XLEN-1:0] rv_word;

    // RV32I major opcodes seen by the execute stage
    typedef enum logic [6:0] {
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_lui   = 7'b0110111
    } rv_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } br_funct;

    localparam logic [HIST_W-1:0] HIST_TAKE = 10'b1110000000; // at or above: taken
    localparam logic [HIST_W-1:0] HIST_WEAK = 10'b0000010000; // below: not taken
    localparam logic [HIST_W-1:0] PRED_FLIP = 10'b1101010000; // disagreement level to invert
    localparam logic [HIST_W-1:0] HIST_NEW  = 10'b1000000000; // one recent taken

    localparam rv_word INVALID_TARGET = '1;

endpackage

// File: btb_entry.sv
`timescale 1ns/1ps

module btb_entry (
    input  logic           clk,
    input  logic           rst,
    input  logic           alloc,            // take over this slot for pc_exe
    input  logic           upd_hist,         // shift in the resolved outcome
    input  logic           branch_taken,
    input  logic           pred_exe,
    input  bp_pkg::rv_word pc_exe,
    input  bp_pkg::rv_word pc_fetch,
    input  bp_pkg::rv_word imm,
    output logic           fetch_hit,
    output logic           exe_hit,
    output logic           branch_prediction,
    output bp_pkg::rv_word branch_target
);

    logic                      valid;
    bp_pkg::rv_word            entry_pc;
    logic [11:0]               offset;      // imm[12:1], bit 0 of a B immediate is always 0
    logic [bp_pkg::HIST_W-1:0] branch_hist; // msb is the newest outcome
    logic [bp_pkg::HIST_W-1:0] pred_hist;   // msb is the newest prediction
    logic [bp_pkg::HIST_W-1:0] hist_diff;

    assign fetch_hit = valid && (pc_fetch == entry_pc);
    assign exe_hit   = valid && (pc_exe == entry_pc);

    assign branch_target = entry_pc + {{(bp_pkg::XLEN - 13){offset[11]}}, offset, 1'b0};

    assign hist_diff = branch_hist ^ pred_hist; // bits where the predictor was wrong

    always_comb begin
        if (branch_hist >= bp_pkg::HIST_TAKE) begin
            branch_prediction = 1'b1;
        end else if (branch_hist < bp_pkg::HIST_WEAK) begin
            branch_prediction = 1'b0;
        end else if (hist_diff >= bp_pkg::PRED_FLIP) begin
            branch_prediction = ~pred_hist[bp_pkg::HIST_W-1]; // recent guesses mostly wrong
        end else begin
            branch_prediction = pred_hist[bp_pkg::HIST_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_pc    <= pc_exe;
            offset      <= imm[12:1];
            branch_hist <= bp_pkg::HIST_NEW;
            pred_hist   <= '0;
        end else if (upd_hist) begin
            branch_hist <= {branch_taken, branch_hist[bp_pkg::HIST_W-1:1]};
            pred_hist   <= {pred_exe, pred_hist[bp_pkg::HIST_W-1:1]};
        end
    end

endmodule

// File: jtb_entry.sv
`timescale 1ns/1ps

module jtb_entry (
    input  logic           clk,
    input  logic           rst,
    input  logic           alloc,
    input  bp_pkg::rv_word pc_exe,
    input  bp_pkg::rv_word pc_fetch,
    input  bp_pkg::rv_word jal_target,
    output logic           fetch_hit,
    output logic           exe_hit,
    output bp_pkg::rv_word jump_target
);

    logic           valid;
    bp_pkg::rv_word entry_pc;
    bp_pkg::rv_word entry_target;

    assign fetch_hit   = valid && (pc_fetch == entry_pc);
    assign exe_hit     = valid && (pc_exe == entry_pc);
    assign jump_target = entry_target;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_pc     <= pc_exe;
            entry_target <= jal_target; // fixed once allocated
        end
    end

endmodule

// File: control_buffer.sv
`timescale 1ns/1ps

module control_buffer #(
    parameter int BTB_ENTRIES = 32,
    parameter int JTB_ENTRIES = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             sel,          // one cycle per resolved instruction
    input  logic             branch_taken,
    input  logic             pred_exe,
    input  bp_pkg::rv_opcode opcode,
    input  bp_pkg::rv_word   pc_exe,
    input  bp_pkg::rv_word   imm,
    input  bp_pkg::rv_word   jal_target,
    input  bp_pkg::rv_word   pc_fetch,
    output logic             prediction,
    output bp_pkg::rv_word   target
);

    localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
    localparam int JTB_IDX_W = $clog2(JTB_ENTRIES);

    logic [BTB_ENTRIES-1:0] br_fetch_hits;
    logic [BTB_ENTRIES-1:0] br_exe_hits;
    logic [BTB_ENTRIES-1:0] br_preds;
    logic [BTB_ENTRIES-1:0] br_alloc;        // one-hot slot write
    logic [BTB_ENTRIES-1:0] br_upd;          // one-hot history shift
    bp_pkg::rv_word         br_targets [BTB_ENTRIES];

    logic [JTB_ENTRIES-1:0] jp_fetch_hits;
    logic [JTB_ENTRIES-1:0] jp_exe_hits;
    logic [JTB_ENTRIES-1:0] jp_alloc;
    bp_pkg::rv_word         jp_targets [JTB_ENTRIES];

    logic [BTB_IDX_W-1:0]   br_head;         // oldest branch slot, next to evict
    logic [JTB_IDX_W-1:0]   jp_head;
    logic [BTB_IDX_W-1:0]   br_fetch_idx;
    logic [JTB_IDX_W-1:0]   jp_fetch_idx;

    logic                   br_alloc_en;
    logic                   jp_alloc_en;
    logic                   br_hist_en;

    for (genvar i = 0; i < BTB_ENTRIES; i++) begin : g_btb
        btb_entry u_entry (
            .clk               (clk),
            .rst               (rst),
            .alloc             (br_alloc[i]),
            .upd_hist          (br_upd[i]),
            .branch_taken      (branch_taken),
            .pred_exe          (pred_exe),
            .pc_exe            (pc_exe),
            .pc_fetch          (pc_fetch),
            .imm               (imm),
            .fetch_hit         (br_fetch_hits[i]),
            .exe_hit           (br_exe_hits[i]),
            .branch_prediction (br_preds[i]),
            .branch_target     (br_targets[i])
        );
    end

    for (genvar j = 0; j < JTB_ENTRIES; j++) begin : g_jtb
        jtb_entry u_entry (
            .clk         (clk),
            .rst         (rst),
            .alloc       (jp_alloc[j]),
            .pc_exe      (pc_exe),
            .pc_fetch    (pc_fetch),
            .jal_target  (jal_target),
            .fetch_hit   (jp_fetch_hits[j]),
            .exe_hit     (jp_exe_hits[j]),
            .jump_target (jp_targets[j])
        );
    end

    // update decode, a known branch only trains its history
    assign br_hist_en  = sel && (opcode == bp_pkg::op_br) && (|br_exe_hits);
    assign br_alloc_en = sel && (opcode == bp_pkg::op_br) && !(|br_exe_hits) && branch_taken;
    assign jp_alloc_en = sel && (opcode == bp_pkg::op_jal) && !(|jp_exe_hits);

    assign br_upd   = br_hist_en ? br_exe_hits : '0; // pcs are unique, so at most one bit
    assign br_alloc = br_alloc_en ? (BTB_ENTRIES'(1) << br_head) : '0;
    assign jp_alloc = jp_alloc_en ? (JTB_ENTRIES'(1) << jp_head) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            br_head <= '0;
            jp_head <= '0;
        end else begin
            if (br_alloc_en) br_head <= br_head + 1'b1; // wraps onto the oldest
            if (jp_alloc_en) jp_head <= jp_head + 1'b1;
        end
    end

    always_comb begin
        br_fetch_idx = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            if (br_fetch_hits[i]) br_fetch_idx = BTB_IDX_W'(i);
        end
    end

    always_comb begin
        jp_fetch_idx = '0;
        for (int j = 0; j < JTB_ENTRIES; j++) begin
            if (jp_fetch_hits[j]) jp_fetch_idx = JTB_IDX_W'(j);
        end
    end

    // branch table wins over the jump table
    always_comb begin
        prediction = 1'b0;
        target     = bp_pkg::INVALID_TARGET;
        if (|br_fetch_hits) begin
            prediction = br_preds[br_fetch_idx];
            if (br_preds[br_fetch_idx]) target = br_targets[br_fetch_idx];
        end else if (|jp_fetch_hits) begin
            prediction = 1'b1;
            target     = jp_targets[jp_fetch_idx];
        end
    end

endmodule

// File: branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
    input  bp_pkg::rv_opcode opcode,
    input  bp_pkg::br_funct  funct3,
    input  bp_pkg::rv_word   rs1_data,
    input  bp_pkg::rv_word   rs2_data,
    input  bp_pkg::rv_word   pc_exe,
    input  bp_pkg::rv_word   imm,       // sign-extended B or J immediate
    input  logic             pred_exe,  // prediction carried down from fetch
    output logic             branch_taken,
    output bp_pkg::rv_word   jal_target,
    output logic             mispredict
);

    logic cond_met;
    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(rs1_data) < $signed(rs2_data);
    assign lt_unsigned = rs1_data < rs2_data;

    always_comb begin
        case (funct3)
            bp_pkg::beq:  cond_met = (rs1_data == rs2_data);
            bp_pkg::bne:  cond_met = (rs1_data != rs2_data);
            bp_pkg::blt:  cond_met = lt_signed;
            bp_pkg::bge:  cond_met = !lt_signed;
            bp_pkg::bltu: cond_met = lt_unsigned;
            bp_pkg::bgeu: cond_met = !lt_unsigned;
            default:      cond_met = 1'b0; // reserved funct3 never branches
        endcase
    end

    always_comb begin
        case (opcode)
            bp_pkg::op_br:  branch_taken = cond_met;
            bp_pkg::op_jal: branch_taken = 1'b1;
            default:        branch_taken = 1'b0;
        endcase
    end

    assign jal_target = pc_exe + imm;

    assign mispredict = branch_taken ^ pred_exe;

endmodule

// File: bp_unit.sv
`timescale 1ns/1ps

module bp_unit #(
    parameter int BTB_ENTRIES = 32,
    parameter int JTB_ENTRIES = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             sel,
    input  bp_pkg::rv_opcode opcode,
    input  bp_pkg::br_funct  funct3,
    input  bp_pkg::rv_word   rs1_data,
    input  bp_pkg::rv_word   rs2_data,
    input  bp_pkg::rv_word   imm,
    input  bp_pkg::rv_word   pc_exe,
    input  logic             pred_exe,
    input  bp_pkg::rv_word   pc_fetch,
    output logic             prediction,
    output bp_pkg::rv_word   target,
    output logic             mispredict
);

    logic           branch_taken;
    bp_pkg::rv_word jal_target;

    branch_resolve u_resolve (
        .opcode       (opcode),
        .funct3       (funct3),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .pc_exe       (pc_exe),
        .imm          (imm),
        .pred_exe     (pred_exe),
        .branch_taken (branch_taken),
        .jal_target   (jal_target),
        .mispredict   (mispredict)
    );

    control_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .JTB_ENTRIES (JTB_ENTRIES)
    ) u_buffer (
        .clk          (clk),
        .rst          (rst),
        .sel          (sel),
        .branch_taken (branch_taken),
        .pred_exe     (pred_exe),
        .opcode       (opcode),
        .pc_exe       (pc_exe),
        .imm          (imm),
        .jal_target   (jal_target),
        .pc_fetch     (pc_fetch),
        .prediction   (prediction),
        .target       (target)
    );

endmodule

// File: bp_unit_asserts.sv
`timescale 1ns/1ps

module bp_unit_asserts #(
    parameter int BTB_ENTRIES = 32,
    parameter int JTB_ENTRIES = 16
) (
    input logic                   clk,
    input logic                   rst,
    input logic                   sel,
    input logic [BTB_ENTRIES-1:0] br_alloc,
    input logic [BTB_ENTRIES-1:0] br_upd,
    input logic [JTB_ENTRIES-1:0] jp_alloc,
    input logic                   prediction,
    input bp_pkg::rv_word         target
);

    int fail_count = 0; // read back by the testbench at the end of the run

    // a duplicate pc in the branch table would raise two history strobes
    one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({br_alloc, br_upd, jp_alloc}))
        else begin
            fail_count = fail_count + 1;
            $error("more than one table strobe in one cycle");
        end

    no_pred_no_target: assert property (@(posedge clk) disable iff (rst)
        !prediction |-> (target == bp_pkg::INVALID_TARGET))
        else begin
            fail_count = fail_count + 1;
            $error("target is not invalid while prediction is low");
        end

    idle_no_strobe: assert property (@(posedge clk) disable iff (rst)
        !sel |-> (br_alloc == '0 && br_upd == '0 && jp_alloc == '0))
        else begin
            fail_count = fail_count + 1;
            $error("table strobe active while sel is low");
        end

endmodule

bind control_buffer bp_unit_asserts #(
    .BTB_ENTRIES (BTB_ENTRIES),
    .JTB_ENTRIES (JTB_ENTRIES)
) u_asserts (
    .clk        (clk),
    .rst        (rst),
    .sel        (sel),
    .br_alloc   (br_alloc),
    .br_upd     (br_upd),
    .jp_alloc   (jp_alloc),
    .prediction (prediction),
    .target     (target)
);

// File: bp_unit_tb.sv
`timescale 1ns/1ps

module bp_unit_tb;

    localparam bp_pkg::rv_opcode BR  = bp_pkg::op_br;
    localparam bp_pkg::rv_opcode JAL = bp_pkg::op_jal;
    localparam bp_pkg::rv_opcode ALU = bp_pkg::op_imm; // never trains the tables
    localparam int NT = -1;                            // all ones when nothing is predicted

    typedef struct packed {
        logic             sel;
        bp_pkg::rv_opcode opcode;
        bp_pkg::br_funct  funct3;
        bp_pkg::rv_word   rs1, rs2, imm, pc_exe, pc_fetch;
        logic             pred_exe;
        logic             exp_pred;
        bp_pkg::rv_word   exp_target;
        logic             exp_mis;
    } row_t;

    logic             clk, rst, sel, pred_exe;
    bp_pkg::rv_opcode opcode;
    bp_pkg::br_funct  funct3;
    bp_pkg::rv_word   rs1_data, rs2_data, imm, pc_exe, pc_fetch;
    logic             prediction, mispredict;
    bp_pkg::rv_word   target;

    row_t  rows[$];
    string names[$];
    int    error_count = 0;
    int    check_count = 0;
    int    cycles = 0;
    int    cycle_limit = 0;

    bp_unit #(
        .BTB_ENTRIES (4),
        .JTB_ENTRIES (4)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .sel        (sel),
        .opcode     (opcode),
        .funct3     (funct3),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc_exe     (pc_exe),
        .pred_exe   (pred_exe),
        .pc_fetch   (pc_fetch),
        .prediction (prediction),
        .target     (target),
        .mispredict (mispredict)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input bp_pkg::rv_word expected,
                               input bp_pkg::rv_word actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_row(input string name, input int s, input bp_pkg::rv_opcode op,
                           input bp_pkg::br_funct f3, input int a, input int b,
                           input int im, input int pc, input int p, input int fp,
                           input int ep, input int et, input int em);
        row_t r;
        r.sel        = (s != 0);
        r.opcode     = op;
        r.funct3     = f3;
        r.rs1        = a;
        r.rs2        = b;
        r.imm        = im;
        r.pc_exe     = pc;
        r.pred_exe   = (p != 0);
        r.pc_fetch   = fp;
        r.exp_pred   = (ep != 0);
        r.exp_target = et;
        r.exp_mis    = (em != 0);
        rows.push_back(r);
        names.push_back(name);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        row_t r;
        int   assert_fails;
        clk      = 1'b0;
        rst      = 1'b1;
        sel      = 1'b0;
        opcode   = ALU;
        funct3   = bp_pkg::beq;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        pc_exe   = '0;
        pred_exe = 1'b0;
        pc_fetch = '0;
        // name, sel, op, funct3, rs1, rs2, imm, pc_exe, pred, pc_fetch, exp pred/target/mis
        add_row("reset pc 0",    0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h000, 0, NT, 0);
        add_row("reset pc 100",  0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h100, 0, NT, 0);
        add_row("beq false",     1, BR, bp_pkg::beq, 1, 2, 'h40, 'h100, 1, 'h100, 0, NT, 1);
        add_row("bltu false",    1, BR, bp_pkg::bltu, -16, 5, 'h40, 'h100, 1, 'h100, 0, NT, 1);
        add_row("bltu no alloc", 0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h100, 0, NT, 0);
        add_row("br alloc",      1, BR, bp_pkg::beq, 7, 7, 'h40, 'h100, 0, 'h100, 0, NT, 1);
        add_row("br train 1",    1, BR, bp_pkg::beq, 7, 7, 'h40, 'h100, 0, 'h100, 0, NT, 1);
        add_row("br train 2",    1, BR, bp_pkg::beq, 7, 7, 'h40, 'h100, 0, 'h100, 0, NT, 1);
        add_row("br strong",     0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h100, 1, 'h140, 0);
        add_row("jal alloc",     1, JAL, bp_pkg::beq, 0, 0, 'h80, 'h300, 0, 'h300, 0, NT, 1);
        add_row("jal reuse",     1, JAL, bp_pkg::beq, 0, 0, 'h100, 'h300, 1, 'h300, 1, 'h380, 0);
        add_row("jal old tgt",   0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h300, 1, 'h380, 0);
        add_row("evict 1",       1, BR, bp_pkg::bne, 1, 2, 'h20, 'h400, 0, 'h100, 1, 'h140, 1);
        add_row("evict 2",       1, BR, bp_pkg::bne, 1, 2, 'h20, 'h404, 0, 'h400, 0, NT, 1);
        add_row("evict 3",       1, BR, bp_pkg::bne, 1, 2, 'h20, 'h408, 0, 'h100, 1, 'h140, 1);
        add_row("evict 4",       1, BR, bp_pkg::bne, 1, 2, 'h20, 'h40c, 0, 'h100, 1, 'h140, 1);
        add_row("evicted",       0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h100, 0, NT, 0);
        add_row("last train 1",  1, BR, bp_pkg::bne, 1, 2, 'h20, 'h40c, 0, 'h40c, 0, NT, 1);
        add_row("last train 2",  1, BR, bp_pkg::bne, 1, 2, 'h20, 'h40c, 0, 'h40c, 0, NT, 1);
        add_row("last hits",     0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h40c, 1, 'h42c, 0);
        add_row("idle beq",      0, BR, bp_pkg::beq, 3, 3, 'h40, 'h500, 0, 'h500, 0, NT, 1);
        add_row("idle bne",      0, BR, bp_pkg::bne, 3, 3, 'h40, 'h500, 1, 'h500, 0, NT, 1);
        add_row("idle blt",      0, BR, bp_pkg::blt, -1, 1, 'h40, 'h500, 1, 'h500, 0, NT, 0);
        add_row("idle bge",      0, BR, bp_pkg::bge, -1, 1, 'h40, 'h500, 1, 'h500, 0, NT, 1);
        add_row("idle bltu",     0, BR, bp_pkg::bltu, -1, 1, 'h40, 'h500, 0, 'h500, 0, NT, 0);
        add_row("idle bgeu",     0, BR, bp_pkg::bgeu, -1, 1, 'h40, 'h500, 0, 'h500, 0, NT, 1);
        add_row("idle no train", 0, BR, bp_pkg::bne, 2, 2, 'h20, 'h40c, 0, 'h40c, 1, 'h42c, 0);
        add_row("idle jal",      0, JAL, bp_pkg::beq, 0, 0, 'h10, 'h600, 0, 'h40c, 1, 'h42c, 1);
        add_row("idle no jal",   0, ALU, bp_pkg::beq, 0, 0, 0, 0, 0, 'h600, 0, NT, 0);
        cycle_limit = rows.size() + 20;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (rows[i]) begin
            r        = rows[i];
            sel      = r.sel;
            opcode   = r.opcode;
            funct3   = r.funct3;
            rs1_data = r.rs1;
            rs2_data = r.rs2;
            imm      = r.imm;
            pc_exe   = r.pc_exe;
            pred_exe = r.pred_exe;
            pc_fetch = r.pc_fetch;
            #16; // just before the edge that writes this row's update
            check_value({names[i], " prediction"}, 32'(r.exp_pred), 32'(prediction));
            check_value({names[i], " target"}, r.exp_target, target);
            check_value({names[i], " mispredict"}, 32'(r.exp_mis), 32'(mispredict));
            @(posedge clk);
            #2;
        end
        assert_fails = u_dut.u_buffer.u_asserts.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: bp_unit.f
bp_pkg.sv
btb_entry.sv
jtb_entry.sv
control_buffer.sv
branch_resolve.sv
bp_unit.sv
bp_unit_asserts.sv
bp_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bp_unit_tb
FILELIST  ?= bp_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
